//--- slow_control_top.f
verilog/sc_pkg.sv
verilog/sc_ctrl.sv
verilog/sc_word_packer.sv
verilog/pulse_sync.sv
verilog/param_fifo.sv
verilog/sr_shifter.sv
verilog/slow_control_top.sv
tests/tb_slow_control_top.sv

//--- run_sim.sh
#!/bin/sh
# build and run the slow-control testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f slow_control_top.f \
  --top-module tb_slow_control_top -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

out=$(./obj_dir/Vtb_slow_control_top)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "Finished with no errors"; then
  exit 0
fi
exit 1

//--- tests/tb_slow_control_top.sv
`timescale 1ns/1ps

module tb_slow_control_top;

  //////////////////////////////////////////////////////////////////////
  // run length
  //////////////////////////////////////////////////////////////////////

  // one serial bit is two clk_5m cycles, 16 clk cycles
  localparam int bit_clks       = 16;
  // bits of all loads: 1 + 3 read-reg chips + 1 + 7 chips
  localparam int total_bits     = 128 + 192 + 128 + 896;
  // the idle window of the asic_num 0 start
  localparam int idle_window    = 2000;
  localparam int timeout_cycles = 4 * (total_bits * bit_clks + idle_window);

  logic                       clk;
  logic                       clk_5m;
  logic                       arst_n;
  logic                       start;
  logic                       sc_or_read;
  logic [2:0]                 asic_num;
  sc_pkg::sc_cfg_t            cfg;
  logic [sc_pkg::rr_bits-1:0] read_reg;
  logic                       select;
  sc_pkg::sr_pins_t           sr;
  logic                       busy;
  logic                       config_done;

  // monitor state
  logic sr_ck;
  logic sr_rstb;
  logic bits[$];
  int   rstb_at_bit[$];
  logic exp_bits[$];
  int   done_cnt;
  int   cycle_cnt;
  integer seed;

  slow_control_top dut0 (
    .clk, .clk_5m, .arst_n, .start, .sc_or_read, .asic_num, .cfg, .read_reg,
    .select, .sr, .busy, .config_done
  );

  always #4 clk = ~clk;
  always #32 clk_5m = ~clk_5m;

  assign sr_ck   = sr.sr_ck;
  assign sr_rstb = sr.sr_rstb;

  //////////////////////////////////////////////////////////////////////
  // monitors
  //////////////////////////////////////////////////////////////////////

  // the chip samples sr_in on the rising shift clock
  always @(posedge sr_ck) begin
    bits.push_back(sr.sr_in);
  end

  // remembers how many bits had gone out when the reset pulse began
  always @(negedge sr_rstb) begin
    rstb_at_bit.push_back(bits.size());
  end

  always @(posedge clk) begin
    if (config_done) begin
      done_cnt <= done_cnt + 1;
    end
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt == timeout_cycles) begin
      $display("timeout, the run did not end within %0d clk cycles", timeout_cycles);
      $display("Finished with errors");
      $fatal(1, "timeout");
    end
  end

  //////////////////////////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////////////////////////

  task automatic stop_on_error();
    $display("Finished with errors");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp) else begin
      $display("[FAIL] %s: got %h expected %h", name, got, exp);
      stop_on_error();
    end
  endtask

  // frame sent msb first, once per chip
  task automatic build_expected(input logic [127:0] frame, input int width, input int chips);
    exp_bits.delete();
    for (int c = 0; c < chips; c++) begin
      for (int b = width - 1; b >= 0; b--) begin
        exp_bits.push_back(frame[b]);
      end
    end
  endtask

  task automatic pulse_start(input logic rr, input logic [2:0] chips);
    @(posedge clk);
    start      <= 1'b1;
    sc_or_read <= rr;
    asic_num   <= chips;
    @(posedge clk);
    start <= 1'b0;
  endtask

  // one full load, optionally with a start fired into the running load
  task automatic do_load(input logic rr, input logic [2:0] chips, input bit extra_start);
    int base;
    int rbase;
    int dbase;
    base  = bits.size();
    rbase = rstb_at_bit.size();
    dbase = done_cnt;
    pulse_start(rr, chips);
    @(posedge clk);
    while (!busy) begin
      @(posedge clk);
    end
    if (extra_start) begin
      pulse_start(1'b1, 3'd7);
    end
    check_value("select", 32'(select), 32'(!rr));
    do begin
      @(posedge clk);
    end while (!config_done);
    // reset pulse starts before the first shift clock of this load
    assert (rstb_at_bit.size() == rbase + 1 && rstb_at_bit[rbase] == base) else begin
      $display("sr_rstb did not pulse low once before the first sr_ck edge");
      stop_on_error();
    end
    check_value("sr_in bit count", 32'(bits.size() - base), 32'(exp_bits.size()));
    for (int i = 0; i < exp_bits.size(); i++) begin
      assert (bits[base + i] === exp_bits[i]) else begin
        $display("[FAIL] sr_in bit %0d: got %h expected %h", i, bits[base + i], exp_bits[i]);
        stop_on_error();
      end
    end
    repeat (20) @(posedge clk);
    check_value("config_done count", 32'(done_cnt - dbase), 32'd1);
    check_value("busy", 32'(busy), 32'd0);
  endtask

  //////////////////////////////////////////////////////////////////////
  // tests
  //////////////////////////////////////////////////////////////////////

  task automatic test_reset_values();
    check_value("busy", 32'(busy), 32'd0);
    check_value("config_done", 32'(config_done), 32'd0);
    check_value("select", 32'(select), 32'd0);
    check_value("sr_ck", 32'(sr.sr_ck), 32'd0);
    check_value("sr_rstb", 32'(sr.sr_rstb), 32'd1);
    check_value("sr_in", 32'(sr.sr_in), 32'd0);
  endtask

  task automatic test_sc_one_chip();
    cfg <= '{header: 8'hc3, dac2_vth: 10'h2d1, dac1_vth: 10'h10e, dac0_vth: 10'h3f0,
             sel_raz: 2'b10, sw_hg: 2'b01, sw_lg: 2'b11, en_flags: 16'ha55a,
             ctest: 64'h0123_4567_89ab_cdef, spare: 4'h9};
    @(posedge clk);
    build_expected(cfg, 128, 1);
    do_load(1'b0, 3'd1, 1'b0);
  endtask

  task automatic test_rr_three_chips();
    // one-hot, channel 37
    read_reg <= 64'd1 << 37;
    @(posedge clk);
    build_expected({64'd0, read_reg}, 64, 3);
    do_load(1'b1, 3'd3, 1'b0);
  endtask

  task automatic test_ignored_starts();
    int base;
    int dbase;
    base  = bits.size();
    dbase = done_cnt;
    // no chip on the chain, nothing may happen
    pulse_start(1'b0, 3'd0);
    repeat (idle_window) @(posedge clk);
    check_value("sr_ck edge count", 32'(bits.size() - base), 32'd0);
    check_value("config_done count", 32'(done_cnt - dbase), 32'd0);
    check_value("busy", 32'(busy), 32'd0);
    // a start while busy must not add frames
    build_expected(cfg, 128, 1);
    do_load(1'b0, 3'd1, 1'b1);
  endtask

  task automatic test_random_seven();
    cfg <= sc_pkg::sc_cfg_t'({$random(seed), $random(seed), $random(seed), $random(seed)});
    @(posedge clk);
    build_expected(cfg, 128, 7);
    do_load(1'b0, 3'd7, 1'b0);
  endtask

  initial begin
    seed       = 32'he2f4_daa9;
    clk        = 1'b0;
    clk_5m     = 1'b0;
    arst_n     = 1'b1;
    start      = 1'b0;
    sc_or_read = 1'b0;
    asic_num   = 3'd0;
    cfg        = '0;
    read_reg   = '0;
    done_cnt   = 0;
    cycle_cnt  = 0;
    // falling edge resets the clk_5m side before its first rise
    #1;
    arst_n = 1'b0;
    repeat (2) @(posedge clk);
    arst_n <= 1'b1;
    @(posedge clk);
    test_reset_values();
    test_sc_one_chip();
    test_rr_three_chips();
    test_ignored_starts();
    test_random_seven();
    $display("Finished with no errors");
    $finish;
  end

endmodule

//--- verilog/slow_control_top.sv
`timescale 1ns/1ps

module slow_control_top (
  input  logic                       clk,
  input  logic                       clk_5m,
  input  logic                       arst_n,
  input  logic                       start,
  input  logic                       sc_or_read,
  input  logic [2:0]                 asic_num,
  input  sc_pkg::sc_cfg_t            cfg,
  input  logic [sc_pkg::rr_bits-1:0] read_reg,
  output logic                       select,
  output sc_pkg::sr_pins_t           sr,
  output logic                       busy,
  output logic                       config_done
);

  sc_pkg::load_cmd_t         cmd;
  logic                      pack_go, pack_done, shift_go;
  logic                      run_end, shift_done;
  logic                      wr_en, rd_en, empty;
  logic [sc_pkg::word_w-1:0] wr_data, rd_data;

  // clk domain, command and packing
  sc_ctrl u_ctrl (
    .clk, .arst_n, .start, .sc_or_read, .asic_num, .shift_done,
    .cmd, .pack_go, .select, .busy, .config_done
  );

  sc_word_packer u_packer (
    .clk, .arst_n, .pack_go, .cmd, .cfg, .read_reg,
    .wr_en, .wr_data, .pack_done
  );

  // words cross clk -> clk_5m, full only feeds the fifo's own checks
  param_fifo u_fifo (
    .wr_clk (clk), .rd_clk (clk_5m), .arst_n, .wr_en, .wr_data,
    .rd_en, .rd_data, .empty, .full ()
  );

  pulse_sync sync_go (
    .clk_src (clk), .clk_dst (clk_5m), .arst_n,
    .pulse_src (pack_done), .pulse_dst (shift_go)
  );

  // clk_5m domain, serial pins
  sr_shifter u_shifter (
    .clk_5m, .arst_n, .shift_go, .rd_data, .empty,
    .rd_en, .sr, .run_end
  );

  pulse_sync sync_end (
    .clk_src (clk_5m), .clk_dst (clk), .arst_n,
    .pulse_src (run_end), .pulse_dst (shift_done)
  );

endmodule

//--- verilog/sr_shifter.sv
`timescale 1ns/1ps

module sr_shifter (
  input  logic                      clk_5m,
  input  logic                      arst_n,
  input  logic                      shift_go,
  input  logic [sc_pkg::word_w-1:0] rd_data,
  input  logic                      empty,
  output logic                      rd_en,
  output sc_pkg::sr_pins_t          sr,
  output logic                      run_end
);

  typedef enum logic [1:0] {ph_idle, ph_rst, ph_fetch, ph_shift} phase_t;

  phase_t                          phase;
  logic [sc_pkg::word_w-1:0]       shreg;
  logic [sc_pkg::bit_cnt_w-1:0]    bit_cnt;
  logic [sc_pkg::rstb_cnt_w-1:0]   rst_cnt;

  // pop the head word at each word boundary
  assign rd_en = (phase == ph_fetch) && !empty;

  always_ff @(posedge clk_5m or negedge arst_n) begin
    if (!arst_n) begin
      phase   <= ph_idle;
      sr      <= '{sr_rstb: 1'b1, sr_ck: 1'b0, sr_in: 1'b0};
      shreg   <= '0;
      bit_cnt <= '0;
      rst_cnt <= '0;
      run_end <= 1'b0;
    end else begin
      run_end <= 1'b0;
      case (phase)
        ph_idle: if (shift_go) begin
          phase      <= ph_rst;
          rst_cnt    <= '0;
          sr.sr_rstb <= 1'b0;
        end
        // hold the chip register in reset
        ph_rst: begin
          rst_cnt <= rst_cnt + 1'b1;
          if (rst_cnt == sc_pkg::rstb_last) begin
            sr.sr_rstb <= 1'b1;
            phase      <= ph_fetch;
          end
        end
        ph_fetch: begin
          if (empty) begin
            // all chips loaded
            phase    <= ph_idle;
            sr.sr_in <= 1'b0;
            run_end  <= 1'b1;
          end else begin
            // msb goes out first, sr_ck still low
            sr.sr_in <= rd_data[sc_pkg::word_w-1];
            shreg    <= {rd_data[sc_pkg::word_w-2:0], 1'b0};
            bit_cnt  <= '0;
            phase    <= ph_shift;
          end
        end
        ph_shift: begin
          if (!sr.sr_ck) begin
            // data settled a cycle ago, chip samples on this rise
            sr.sr_ck <= 1'b1;
          end else begin
            sr.sr_ck <= 1'b0;
            if (bit_cnt == sc_pkg::bit_last) begin
              phase <= ph_fetch;
            end else begin
              sr.sr_in <= shreg[sc_pkg::word_w-1];
              shreg    <= {shreg[sc_pkg::word_w-2:0], 1'b0};
              bit_cnt  <= bit_cnt + 1'b1;
            end
          end
        end
        default: phase <= ph_idle;
      endcase
    end
  end

  // a new run only starts once the last one has ended
  a_go_while_running : assert property (
    @(posedge clk_5m) disable iff (!arst_n) shift_go |-> (phase == ph_idle));

endmodule

//--- verilog/param_fifo.sv
`timescale 1ns/1ps

module param_fifo (
  input  logic                      wr_clk,
  input  logic                      rd_clk,
  input  logic                      arst_n,
  input  logic                      wr_en,
  input  logic [sc_pkg::word_w-1:0] wr_data,
  input  logic                      rd_en,
  output logic [sc_pkg::word_w-1:0] rd_data,
  output logic                      empty,
  output logic                      full
);

  localparam int aw = sc_pkg::fifo_aw;

  logic [sc_pkg::word_w-1:0] mem [sc_pkg::fifo_depth];

  // one extra msb tells full from empty
  logic [aw:0] wr_bin, wr_gray, wr_bin_nxt;
  logic [aw:0] rd_bin, rd_gray, rd_bin_nxt;
  logic [aw:0] wr_gray_s1, wr_gray_s2;
  logic [aw:0] rd_gray_s1, rd_gray_s2;

  //////////////////////////////////////////////////////////////////////
  // write side, clk domain
  //////////////////////////////////////////////////////////////////////

  assign wr_bin_nxt = wr_bin + 1'b1;
  // full when the top two gray bits differ and the rest match
  assign full = (wr_gray == {~rd_gray_s2[aw:aw-1], rd_gray_s2[aw-2:0]});

  always_ff @(posedge wr_clk) begin
    if (wr_en && !full) begin
      mem[wr_bin[aw-1:0]] <= wr_data;
    end
  end

  always_ff @(posedge wr_clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_bin     <= '0;
      wr_gray    <= '0;
      rd_gray_s1 <= '0;
      rd_gray_s2 <= '0;
    end else begin
      if (wr_en && !full) begin
        wr_bin  <= wr_bin_nxt;
        wr_gray <= (wr_bin_nxt >> 1) ^ wr_bin_nxt;
      end
      // read pointer into the write domain
      rd_gray_s1 <= rd_gray;
      rd_gray_s2 <= rd_gray_s1;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // read side, clk_5m domain
  //////////////////////////////////////////////////////////////////////

  assign rd_bin_nxt = rd_bin + 1'b1;
  assign empty      = (rd_gray == wr_gray_s2);
  // head word shows without a read, rd_en pops it
  assign rd_data    = mem[rd_bin[aw-1:0]];

  always_ff @(posedge rd_clk or negedge arst_n) begin
    if (!arst_n) begin
      rd_bin     <= '0;
      rd_gray    <= '0;
      wr_gray_s1 <= '0;
      wr_gray_s2 <= '0;
    end else begin
      if (rd_en && !empty) begin
        rd_bin  <= rd_bin_nxt;
        rd_gray <= (rd_bin_nxt >> 1) ^ rd_bin_nxt;
      end
      wr_gray_s1 <= wr_gray;
      wr_gray_s2 <= wr_gray_s1;
    end
  end

  a_no_write_full : assert property (
    @(posedge wr_clk) disable iff (!arst_n) wr_en |-> !full);
  a_no_read_empty : assert property (
    @(posedge rd_clk) disable iff (!arst_n) rd_en |-> !empty);

endmodule

//--- verilog/pulse_sync.sv
`timescale 1ns/1ps

module pulse_sync (
  input  logic clk_src,
  input  logic clk_dst,
  input  logic arst_n,
  input  logic pulse_src,
  output logic pulse_dst
);

  logic       tgl_src;
  // two sync stages plus one for the edge detect
  logic [2:0] sync_dst;

  // each source strobe flips the level
  always_ff @(posedge clk_src or negedge arst_n) begin
    if (!arst_n) begin
      tgl_src <= 1'b0;
    end else if (pulse_src) begin
      tgl_src <= !tgl_src;
    end
  end

  always_ff @(posedge clk_dst or negedge arst_n) begin
    if (!arst_n) begin
      sync_dst <= '0;
    end else begin
      sync_dst <= {sync_dst[1:0], tgl_src};
    end
  end

  // any change of the synced level is one strobe
  assign pulse_dst = sync_dst[2] ^ sync_dst[1];

endmodule

//--- verilog/sc_word_packer.sv
`timescale 1ns/1ps

module sc_word_packer (
  input  logic                      clk,
  input  logic                      arst_n,
  input  logic                      pack_go,
  input  sc_pkg::load_cmd_t         cmd,
  input  sc_pkg::sc_cfg_t           cfg,
  input  logic [sc_pkg::rr_bits-1:0] read_reg,
  output logic                      wr_en,
  output logic [sc_pkg::word_w-1:0] wr_data,
  output logic                      pack_done
);

  logic [sc_pkg::idx_w-1:0]   word_idx;
  logic [sc_pkg::idx_w-1:0]   last_idx;
  logic [2:0]                 chip_cnt;
  logic [sc_pkg::sc_bits-1:0] frame;

  // read register sits in the top half so both frames slice alike
  assign frame    = cmd.mode ? cfg : {read_reg, {(sc_pkg::sc_bits - sc_pkg::rr_bits){1'b0}}};
  assign last_idx = cmd.mode ? sc_pkg::sc_last : sc_pkg::rr_last;
  // word 0 is the msb end of the frame
  assign wr_data  = frame[sc_pkg::sc_bits - 1 - word_idx * sc_pkg::word_w -: sc_pkg::word_w];

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_en     <= 1'b0;
      word_idx  <= '0;
      chip_cnt  <= '0;
      pack_done <= 1'b0;
    end else begin
      pack_done <= 1'b0;
      if (pack_go) begin
        wr_en    <= 1'b1;
        word_idx <= '0;
        chip_cnt <= '0;
      end else if (wr_en) begin
        if (word_idx == last_idx) begin
          // end of one frame, wrap for the next chip or stop
          word_idx <= '0;
          if (chip_cnt == cmd.chips - 3'd1) begin
            wr_en     <= 1'b0;
            pack_done <= 1'b1;
          end else begin
            chip_cnt <= chip_cnt + 3'd1;
          end
        end else begin
          word_idx <= word_idx + 1'b1;
        end
      end
    end
  end

  // a new load never overlaps the one being written
  a_go_while_writing : assert property (
    @(posedge clk) disable iff (!arst_n) pack_go |-> !wr_en);

endmodule

//--- verilog/sc_ctrl.sv
`timescale 1ns/1ps

module sc_ctrl (
  input  logic               clk,
  input  logic               arst_n,
  input  logic               start,
  input  logic               sc_or_read,
  input  logic [2:0]         asic_num,
  input  logic               shift_done,
  output sc_pkg::load_cmd_t  cmd,
  output logic               pack_go,
  output logic               select,
  output logic               busy,
  output logic               config_done
);

  typedef enum logic {st_idle, st_load} state_t;

  state_t state;
  logic   accept;

  // starts only count when idle and at least one chip is on the chain
  assign accept = (state == st_idle) && start && (asic_num != 3'd0);
  assign busy   = (state == st_load);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state       <= st_idle;
      pack_go     <= 1'b0;
      select      <= 1'b0;
      config_done <= 1'b0;
    end else begin
      // strobes default low
      pack_go     <= 1'b0;
      config_done <= 1'b0;
      if (accept) begin
        state   <= st_load;
        pack_go <= 1'b1;
        // select = 1 routes the pins to the slow-control register
        select  <= !sc_or_read;
      end else if (busy && shift_done) begin
        state       <= st_idle;
        config_done <= 1'b1;
      end
    end
  end

  // command held for the packer until the next accepted start
  always_ff @(posedge clk) begin
    if (accept) begin
      cmd.mode  <= !sc_or_read;
      cmd.chips <= asic_num;
    end
  end

  // the serial side only ever finishes a load this block started
  a_done_while_busy : assert property (
    @(posedge clk) disable iff (!arst_n) shift_done |-> busy);

endmodule

//--- verilog/sc_pkg.sv
package sc_pkg;

  //////////////////////////////////////////////////////////////////////
  // sizes
  //////////////////////////////////////////////////////////////////////

  // fifo word, also the unit the packer slices frames into
  localparam int word_w      = 16;
  // slow-control frame, cut down from the 592 bits of the chip
  localparam int sc_bits     = 128;
  // read register, one-hot channel select
  localparam int rr_bits     = 64;
  localparam int sc_words    = sc_bits / word_w;
  localparam int rr_words    = rr_bits / word_w;
  // 7 chips x 8 words = 56, fits without back-pressure
  localparam int fifo_depth  = 64;
  localparam int fifo_aw     = $clog2(fifo_depth);
  // sr_rstb low time in clk_5m cycles
  localparam int rstb_cycles = 4;

  // counter widths and their terminal counts
  localparam int idx_w      = $clog2(sc_words);
  localparam int bit_cnt_w  = $clog2(word_w);
  localparam int rstb_cnt_w = $clog2(rstb_cycles);
  localparam logic [idx_w-1:0]      sc_last   = idx_w'(sc_words - 1);
  localparam logic [idx_w-1:0]      rr_last   = idx_w'(rr_words - 1);
  localparam logic [bit_cnt_w-1:0]  bit_last  = bit_cnt_w'(word_w - 1);
  localparam logic [rstb_cnt_w-1:0] rstb_last = rstb_cnt_w'(rstb_cycles - 1);

  //////////////////////////////////////////////////////////////////////
  // types
  //////////////////////////////////////////////////////////////////////

  // slow-control frame, msb goes out first
  typedef struct packed {
    logic [7:0]  header;
    logic [9:0]  dac2_vth;
    logic [9:0]  dac1_vth;
    logic [9:0]  dac0_vth;
    logic [1:0]  sel_raz;
    logic [1:0]  sw_hg;
    logic [1:0]  sw_lg;
    logic [15:0] en_flags;
    logic [63:0] ctest;
    logic [3:0]  spare;
  } sc_cfg_t;

  // latched load request, mode 1 = slow control, 0 = read register
  typedef struct packed {
    logic       mode;
    logic [2:0] chips;
  } load_cmd_t;

  // serial pins shared by both chip registers
  typedef struct packed {
    logic sr_rstb;
    logic sr_ck;
    logic sr_in;
  } sr_pins_t;

endpackage
